/* rtl/lsu_cfg.svh */
// bus and datapath widths for the load/store unit
// the realignment logic assumes a 32-bit word with four byte lanes,
// so these values are not free to change
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// byte address width
`define LSU_AW 32

// data bus width
`define LSU_DW 32

// byte lanes on the data bus
`define LSU_NBYTES 4

`endif

/* rtl/lsu_ctrl_fsm.sv */
// bus sequencing for one load or store at a time
// split accesses rely on in-order responses and at most two outstanding
// requests; the core must follow addr_incr_req_o in the same cycle
`default_nettype none

`include "lsu_cfg.svh"

module lsu_ctrl_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // execute stage
  input  logic                  lsu_req_i,
  input  lsu_pkg::lsu_size_e    lsu_type_i,
  input  logic [`LSU_AW-1:0]    adder_result_ex_i,

  // bus responses
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  logic                  data_bus_err_i,

  lsu_ctrl_if.fsm               ctrl,

  output logic                  data_req_o,
  output logic                  addr_incr_req_o,
  output logic                  lsu_req_done_o,
  output logic                  lsu_resp_valid_o,
  output logic                  lsu_rdata_valid_o,
  output logic                  load_err_o,
  output logic                  store_err_o,
  output logic                  busy_o,
  output logic [`LSU_AW-1:0]    addr_last_o
);

  import lsu_pkg::*;

  ls_fsm_e              ls_fsm_cs, ls_fsm_ns;
  logic                 handle_misaligned_q, handle_misaligned_d;
  // bus error seen on the first half
  logic                 lsu_err_q, lsu_err_d;
  logic                 split_access;
  logic                 addr_update;
  logic                 resp_err;
  logic [`LSU_AW-1:0]   addr_w_aligned;
  logic [`LSU_AW-1:0]   addr_last_q, addr_last_d;

  // word access off a word boundary, or half word crossing into the next word
  assign split_access =
      ((lsu_type_i == lsu_word) && (adder_result_ex_i[1:0] != 2'b00)) ||
      ((lsu_type_i == lsu_half) && (adder_result_ex_i[1:0] == 2'b11));

  assign addr_w_aligned = {adder_result_ex_i[`LSU_AW-1:2], 2'b00};

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    ls_fsm_ns             = ls_fsm_cs;
    data_req_o            = 1'b0;
    addr_incr_req_o       = 1'b0;
    handle_misaligned_d   = handle_misaligned_q;
    lsu_err_d             = lsu_err_q;
    addr_update           = 1'b0;
    ctrl.ctrl_update      = 1'b0;
    ctrl.rdata_update     = 1'b0;

    unique case (ls_fsm_cs)
      idle: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          lsu_err_d  = 1'b0;
          if (data_gnt_i) begin
            ctrl.ctrl_update    = 1'b1;
            addr_update         = 1'b1;
            handle_misaligned_d = split_access;
            ls_fsm_ns           = split_access ? wait_rvalid_mis : idle;
          end else begin
            ls_fsm_ns           = split_access ? wait_gnt_mis : wait_gnt;
          end
        end
      end

      // first half of a split access still waits for its grant
      wait_gnt_mis: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl.ctrl_update    = 1'b1;
          addr_update         = 1'b1;
          handle_misaligned_d = 1'b1;
          ls_fsm_ns           = wait_rvalid_mis;
        end
      end

      // second half goes out while the first response is pending
      wait_rvalid_mis: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          lsu_err_d         = data_bus_err_i;
          // stores have nothing to keep
          ctrl.rdata_update = ~ctrl.data_we_q;
          // a failing first half keeps its own address for the trap
          addr_update         = data_gnt_i & ~data_bus_err_i;
          handle_misaligned_d = ~data_gnt_i;
          ls_fsm_ns           = data_gnt_i ? idle : wait_gnt;
        end else if (data_gnt_i) begin
          handle_misaligned_d = 1'b0;
          ls_fsm_ns           = wait_rvalid_mis_gnts_done;
        end
      end

      // aligned access, or second half once the first response is in
      wait_gnt: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = handle_misaligned_q;
        if (data_gnt_i) begin
          ctrl.ctrl_update    = 1'b1;
          addr_update         = ~lsu_err_q;
          handle_misaligned_d = 1'b0;
          ls_fsm_ns           = idle;
        end
      end

      // both halves granted, first response still missing
      wait_rvalid_mis_gnts_done: begin
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          lsu_err_d         = data_bus_err_i;
          addr_update       = ~data_bus_err_i;
          ctrl.rdata_update = ~ctrl.data_we_q;
          ls_fsm_ns         = idle;
        end
      end

      default: begin
        ls_fsm_ns = idle;
      end
    endcase
  end

  // full byte address except while the second half is addressed
  assign addr_last_d = addr_incr_req_o ? addr_w_aligned : adder_result_ex_i;

  //////////////////////////////
  // state registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ls_fsm_cs           <= idle;
      handle_misaligned_q <= 1'b0;
      lsu_err_q           <= 1'b0;
      addr_last_q         <= '0;
    end else begin
      ls_fsm_cs           <= ls_fsm_ns;
      handle_misaligned_q <= handle_misaligned_d;
      lsu_err_q           <= lsu_err_d;
      if (addr_update) begin
        addr_last_q <= addr_last_d;
      end
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  assign ctrl.handle_misaligned = handle_misaligned_q;
  assign addr_last_o            = addr_last_q;

  // address phase complete when the FSM heads back to idle
  assign lsu_req_done_o = (lsu_req_i | (ls_fsm_cs != idle)) & (ls_fsm_ns == idle);

  // last response of any access lands in idle
  assign lsu_resp_valid_o  = data_rvalid_i & (ls_fsm_cs == idle);
  assign resp_err          = lsu_err_q | data_bus_err_i;
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~resp_err & ~ctrl.data_we_q;

  // error type follows the captured write flag
  assign load_err_o  = lsu_resp_valid_o & resp_err & ~ctrl.data_we_q;
  assign store_err_o = lsu_resp_valid_o & resp_err &  ctrl.data_we_q;

  assign busy_o = (ls_fsm_cs != idle);

endmodule

`default_nettype wire

/* rtl/lsu_ctrl_if.sv */
// strobes between the control FSM and the two datapath blocks
// all signals are single bit, the two update strobes are combinational
// and the other two signals are registered in the owning block
`default_nettype none

interface lsu_ctrl_if;

  // capture the transaction attributes
  logic ctrl_update;
  // capture the first-half read word
  logic rdata_update;
  // second half of a split access is on the bus
  logic handle_misaligned;
  // captured write flag of the outstanding access
  logic data_we_q;

  // control FSM side
  modport fsm (
    output ctrl_update,
    output rdata_update,
    output handle_misaligned,
    input  data_we_q
  );

  // store path only needs to know which half is issued
  modport wdata (
    input  handle_misaligned
  );

  // load path
  modport rdata (
    input  ctrl_update,
    input  rdata_update,
    output data_we_q
  );

endinterface

`default_nettype wire

/* rtl/lsu_pkg.sv */
// shared types of the load/store unit
// size code 2'b11 has no name and is handled as a byte access everywhere
`default_nettype none

package lsu_pkg;

  //////////////////////////////
  // access size
  //////////////////////////////

  // encoding follows the execute stage type field
  typedef enum logic [1:0] {
    lsu_word = 2'b00,
    lsu_half = 2'b01,
    lsu_byte = 2'b10
  } lsu_size_e;

  //////////////////////////////
  // control FSM states
  //////////////////////////////

  // mis states belong to split accesses
  typedef enum logic [2:0] {
    idle,
    wait_gnt_mis,
    wait_rvalid_mis,
    wait_gnt,
    wait_rvalid_mis_gnts_done
  } ls_fsm_e;

endpackage

`default_nettype wire

/* rtl/lsu_rdata_align.sv */
// load realignment and extension
// lsu_rdata_o is combinational from data_rdata_i and only meaningful
// in the response cycle of a load
`default_nettype none

`include "lsu_cfg.svh"

module lsu_rdata_align (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [1:0]           offset_i,
  input  lsu_pkg::lsu_size_e   lsu_type_i,
  input  logic                 lsu_sign_ext_i,
  input  logic                 lsu_we_i,
  input  logic [`LSU_DW-1:0]   data_rdata_i,
  lsu_ctrl_if.rdata            ctrl,
  output logic [`LSU_DW-1:0]   lsu_rdata_o
);

  import lsu_pkg::*;

  // captured transaction attributes
  logic [1:0]           offset_q;
  lsu_size_e            type_q;
  logic                 sign_ext_q;
  logic                 we_q;
  // upper three bytes of the first-half word
  logic [`LSU_DW-1:8]   rdata_q;

  // realigned candidates per size
  logic [`LSU_DW-1:0]   rdata_w;
  logic [15:0]          rdata_h;
  logic [7:0]           rdata_b;

  //////////////////////////////
  // capture registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= 2'b00;
      type_q     <= lsu_word;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
    end else if (ctrl.ctrl_update) begin
      offset_q   <= offset_i;
      type_q     <= lsu_type_i;
      sign_ext_q <= lsu_sign_ext_i;
      we_q       <= lsu_we_i;
    end
  end

  // byte 0 of the first word is never part of a split result
  always_ff @(posedge clk_i) begin
    if (ctrl.rdata_update) begin
      rdata_q <= data_rdata_i[`LSU_DW-1:8];
    end
  end

  assign ctrl.data_we_q = we_q;

  //////////////////////////////
  // realignment
  //////////////////////////////

  // word, nonzero offsets are always split
  always_comb begin
    case (offset_q)
      2'b00:   rdata_w = data_rdata_i;
      2'b01:   rdata_w = {data_rdata_i[7:0],  rdata_q[31:8]};
      2'b10:   rdata_w = {data_rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  // half word, only offset 3 takes the held byte
  always_comb begin
    case (offset_q)
      2'b00:   rdata_h = data_rdata_i[15:0];
      2'b01:   rdata_h = data_rdata_i[23:8];
      2'b10:   rdata_h = data_rdata_i[31:16];
      default: rdata_h = {data_rdata_i[7:0], rdata_q[31:24]};
    endcase
  end

  // byte lane picked straight from the offset
  assign rdata_b = data_rdata_i[{offset_q, 3'b000} +: 8];

  //////////////////////////////
  // extension
  //////////////////////////////

  always_comb begin
    case (type_q)
      lsu_word: lsu_rdata_o = rdata_w;
      lsu_half: lsu_rdata_o = {{16{sign_ext_q & rdata_h[15]}}, rdata_h};
      // byte and the unused code
      default:  lsu_rdata_o = {{24{sign_ext_q & rdata_b[7]}}, rdata_b};
    endcase
  end

endmodule

`default_nettype wire

/* rtl/lsu_top.sv */
// load/store unit for a 32-bit core, one access at a time
// during addr_incr_req_o the core presents the first byte address plus 4,
// keeping the byte offset; inputs stay held until lsu_req_done_o
`default_nettype none

`include "lsu_cfg.svh"

module lsu_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // execute stage
  input  logic                     lsu_req_i,
  input  logic                     lsu_we_i,
  input  lsu_pkg::lsu_size_e       lsu_type_i,
  input  logic                     lsu_sign_ext_i,
  input  logic [`LSU_DW-1:0]       lsu_wdata_i,
  input  logic [`LSU_AW-1:0]       adder_result_ex_i,

  // data bus
  input  logic                     data_gnt_i,
  input  logic                     data_rvalid_i,
  input  logic                     data_bus_err_i,
  input  logic [`LSU_DW-1:0]       data_rdata_i,
  output logic                     data_req_o,
  output logic [`LSU_AW-1:0]       data_addr_o,
  output logic                     data_we_o,
  output logic [`LSU_NBYTES-1:0]   data_be_o,
  output logic [`LSU_DW-1:0]       data_wdata_o,

  // results to the core
  output logic [`LSU_DW-1:0]       lsu_rdata_o,
  output logic                     lsu_rdata_valid_o,
  output logic                     lsu_resp_valid_o,
  output logic                     lsu_req_done_o,
  output logic                     addr_incr_req_o,
  output logic [`LSU_AW-1:0]       addr_last_o,
  output logic                     load_err_o,
  output logic                     store_err_o,
  output logic                     busy_o
);

  logic [1:0] data_offset;

  lsu_ctrl_if ctrl_if ();

  // byte offset inside the word
  assign data_offset = adder_result_ex_i[1:0];

  // bus address is always word aligned
  assign data_addr_o = {adder_result_ex_i[`LSU_AW-1:2], 2'b00};
  assign data_we_o   = lsu_we_i;

  //////////////////////////////
  // control
  //////////////////////////////

  lsu_ctrl_fsm u_ctrl_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .lsu_type_i        (lsu_type_i),
    .adder_result_ex_i (adder_result_ex_i),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_bus_err_i    (data_bus_err_i),
    .ctrl              (ctrl_if),
    .data_req_o        (data_req_o),
    .addr_incr_req_o   (addr_incr_req_o),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o),
    .addr_last_o       (addr_last_o)
  );

  //////////////////////////////
  // datapath
  //////////////////////////////

  lsu_wdata_align u_wdata_align (
    .lsu_type_i   (lsu_type_i),
    .offset_i     (data_offset),
    .lsu_wdata_i  (lsu_wdata_i),
    .ctrl         (ctrl_if),
    .data_be_o    (data_be_o),
    .data_wdata_o (data_wdata_o)
  );

  lsu_rdata_align u_rdata_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .offset_i       (data_offset),
    .lsu_type_i     (lsu_type_i),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .lsu_we_i       (lsu_we_i),
    .data_rdata_i   (data_rdata_i),
    .ctrl           (ctrl_if),
    .lsu_rdata_o    (lsu_rdata_o)
  );

endmodule

`default_nettype wire

/* rtl/lsu_wdata_align.sv */
// store data rotation and byte enables, purely combinational
// offset_i must keep the byte offset of the first address in both halves
`default_nettype none

`include "lsu_cfg.svh"

module lsu_wdata_align (
  input  lsu_pkg::lsu_size_e       lsu_type_i,
  input  logic [1:0]               offset_i,
  input  logic [`LSU_DW-1:0]       lsu_wdata_i,
  lsu_ctrl_if.wdata                ctrl,
  output logic [`LSU_NBYTES-1:0]   data_be_o,
  output logic [`LSU_DW-1:0]       data_wdata_o
);

  import lsu_pkg::*;

  //////////////////////////////
  // byte enables
  //////////////////////////////

  always_comb begin
    case (lsu_type_i)
      lsu_word: begin
        if (!ctrl.handle_misaligned) begin
          // upper lanes from the offset up
          case (offset_i)
            2'b00:   data_be_o = 4'b1111;
            2'b01:   data_be_o = 4'b1110;
            2'b10:   data_be_o = 4'b1100;
            default: data_be_o = 4'b1000;
          endcase
        end else begin
          // low lanes that spill into the next word
          case (offset_i)
            2'b00:   data_be_o = 4'b0000;
            2'b01:   data_be_o = 4'b0001;
            2'b10:   data_be_o = 4'b0011;
            default: data_be_o = 4'b0111;
          endcase
        end
      end
      lsu_half: begin
        if (!ctrl.handle_misaligned) begin
          case (offset_i)
            2'b00:   data_be_o = 4'b0011;
            2'b01:   data_be_o = 4'b0110;
            2'b10:   data_be_o = 4'b1100;
            default: data_be_o = 4'b1000;
          endcase
        end else begin
          // only offset 3 splits, one byte left over
          data_be_o = 4'b0001;
        end
      end
      // byte, and the unused size code
      default: data_be_o = 4'b0001 << offset_i;
    endcase
  end

  //////////////////////////////
  // store data rotation
  //////////////////////////////

  // rotate left by the offset so byte 0 lands in its lane
  always_comb begin
    case (offset_i)
      2'b00:   data_wdata_o = lsu_wdata_i;
      2'b01:   data_wdata_o = {lsu_wdata_i[23:0], lsu_wdata_i[31:24]};
      2'b10:   data_wdata_o = {lsu_wdata_i[15:0], lsu_wdata_i[31:16]};
      default: data_wdata_o = {lsu_wdata_i[7:0],  lsu_wdata_i[31:8]};
    endcase
  end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# compile and run the load/store unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module lsu_tb -f sim.f

./obj_dir/Vlsu_tb | tee sim.log

if grep -q "Done: no errors" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

/* sim.f */
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_ctrl_if.sv
rtl/lsu_ctrl_fsm.sv
rtl/lsu_wdata_align.sv
rtl/lsu_rdata_align.sv
rtl/lsu_top.sv
verification/tb_clk_gen.sv
verification/lsu_assert.sv
verification/lsu_tb.sv

/* verification/lsu_assert.sv */
// bus and FSM properties of the load/store unit, bound into lsu_top
// fsm_state_i is taken from the control FSM state register
`default_nettype none

`include "lsu_cfg.svh"

module lsu_assert (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               data_req_i,
  input  logic               data_gnt_i,
  input  logic [`LSU_AW-1:0] data_addr_i,
  input  logic               busy_i,
  input  logic [2:0]         fsm_state_i
);

  import lsu_pkg::*;

  // bus address carries no byte offset
  a_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
      data_req_i |-> (data_addr_i[1:0] == 2'b00))
    else $error("data_addr_o not word aligned during a request");

  // only the five encoded states
  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
      fsm_state_i inside {idle, wait_gnt_mis, wait_rvalid_mis, wait_gnt,
                          wait_rvalid_mis_gnts_done})
    else $error("control FSM in an undefined state");

  // request is held until granted
  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (data_req_i && !data_gnt_i) |=> data_req_i)
    else $error("data_req_o dropped before its grant");

  a_busy_reset: assert property (@(posedge clk_i)
      !rst_ni |-> !busy_i)
    else $error("busy_o high during reset");

endmodule

`default_nettype wire

/* verification/lsu_tb.sv */
// random loads and stores against a byte shadow model and a bus memory
// addresses stay inside a 64-word window, and the core follows
// addr_incr_req_o with the first address plus 4
`default_nettype none

module lsu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import lsu_pkg::*;

  localparam int NUM_OPS    = 400;
  localparam int MAX_CYCLES = NUM_OPS * 20;

  logic        clk_i, rst_ni;
  logic        lsu_req_i, lsu_we_i, lsu_sign_ext_i;
  lsu_size_e   lsu_type_i;
  logic [31:0] lsu_wdata_i, adder_result_ex_i;
  logic        data_gnt_i, data_rvalid_i, data_bus_err_i;
  logic [31:0] data_rdata_i;
  logic        data_req_o, data_we_o;
  logic [31:0] data_addr_o, data_wdata_o;
  logic [3:0]  data_be_o;
  logic [31:0] lsu_rdata_o, addr_last_o;
  logic        lsu_rdata_valid_o, lsu_resp_valid_o, lsu_req_done_o;
  logic        addr_incr_req_o, load_err_o, store_err_o, busy_o;

  integer      seed;
  logic [31:0] rnd;
  // bus memory and the byte shadow it is checked against
  logic [31:0] mem [0:63];
  logic [7:0]  shadow [0:255];
  // outstanding responses, oldest first
  logic [31:0] q_rdata [$];
  logic        q_err [$];
  int          q_due [$];
  int          cycle, gnt_wait, errors, checks, timeouts, ops_started, ops_done;
  // current operation
  logic [31:0] op_addr, op_wdata;
  int          op_bytes, op_grants, op_dones;
  logic        op_active, op_req, op_split, op_we, op_sign;
  logic [1:0]  half_err;
  logic [31:0] first_word;

  tb_clk_gen u_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  lsu_top u_lsu_top (.*);

  bind lsu_top lsu_assert u_lsu_assert (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .data_req_i  (data_req_o),
    .data_gnt_i  (data_gnt_i),
    .data_addr_i (data_addr_o),
    .busy_i      (busy_o),
    .fsm_state_i (u_ctrl_fsm.ls_fsm_cs)
  );

  task automatic check_eq(input logic [31:0] act, input logic [31:0] exp, input string msg);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %0t: %s, got %h expected %h", $time, msg, act, exp);
    end
  endtask

  function automatic int size_bytes(input lsu_size_e t);
    if (t == lsu_word) return 4;
    if (t == lsu_half) return 2;
    // unused code behaves as byte
    return 1;
  endfunction

  // little-endian gather from the shadow, then extension by size
  function automatic logic [31:0] expected_load();
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < op_bytes; i++) begin
      v[8*i +: 8] = shadow[int'(op_addr[7:0]) + i];
    end
    if (op_sign && op_bytes == 2 && v[15]) v[31:16] = '1;
    if (op_sign && op_bytes == 1 && v[7]) v[31:8] = '1;
    return v;
  endfunction

  ////////////////////////////////
  // core model
  ////////////////////////////////

  task automatic start_op();
    rnd = $random(seed);
    lsu_we_i       = rnd[0];
    lsu_sign_ext_i = rnd[1];
    lsu_type_i     = lsu_size_e'(rnd[3:2]);
    rnd = $random(seed);
    // keep the last byte of any access inside the window
    op_addr = {24'h0, rnd[7:0]};
    if (op_addr > 32'd251) op_addr = op_addr - 32'd8;
    lsu_wdata_i = $random(seed);
    op_wdata    = lsu_wdata_i;
    op_we       = lsu_we_i;
    op_sign     = lsu_sign_ext_i;
    op_bytes    = size_bytes(lsu_type_i);
    // access crosses into the next word
    op_split    = (int'(op_addr[1:0]) + op_bytes) > 4;
    op_grants   = 0;
    op_dones    = 0;
    half_err    = 2'b00;
    op_active   = 1'b1;
    op_req      = 1'b1;
    ops_started++;
  endtask

  task automatic finish_op();
    logic        any_err;
    logic [31:0] exp_last;
    int          b;
    any_err  = half_err[0] | half_err[1];
    // failing half keeps its address, else the last accepted one
    exp_last = half_err[0] ? op_addr : (op_split ? ((op_addr + 32'd4) & ~32'h3) : op_addr);
    check_eq(op_grants, op_split ? 2 : 1, "bus requests per access");
    check_eq(op_dones, 1, "done pulses per access");
    check_eq(32'(load_err_o), 32'(any_err && !op_we), "load_err_o");
    check_eq(32'(store_err_o), 32'(any_err && op_we), "store_err_o");
    check_eq(32'(lsu_rdata_valid_o), 32'(!any_err && !op_we), "lsu_rdata_valid_o");
    check_eq(addr_last_o, exp_last, "addr_last_o");
    if (!op_we && !any_err) check_eq(lsu_rdata_o, expected_load(), "load data");
    // store bytes land unless their half failed
    if (op_we) begin
      for (int i = 0; i < op_bytes; i++) begin
        b = int'(op_addr[7:0]) + i;
        if (!half_err[(b / 4 != int'(op_addr[7:2])) ? 1 : 0]) begin
          shadow[b] = op_wdata[8*i +: 8];
        end
      end
    end
    op_active = 1'b0;
    ops_done++;
  endtask

  ////////////////////////////////
  // memory model
  ////////////////////////////////

  task automatic accept_grant();
    logic [5:0] idx;
    logic       err;
    idx = data_addr_o[7:2];
    rnd = $random(seed);
    // about one response in sixteen fails
    err = (rnd[3:0] == 4'h0);
    if (op_grants == 0) begin
      first_word  = data_addr_o;
      half_err[0] = err;
    end else begin
      check_eq(data_addr_o, first_word + 32'd4, "second half word address");
      half_err[1] = err;
    end
    q_rdata.push_back(mem[idx]);
    q_err.push_back(err);
    q_due.push_back(cycle + 1 + (int'(rnd[5:4]) % 3));
    if (data_we_o && !err) begin
      for (int l = 0; l < 4; l++) begin
        if (data_be_o[l]) mem[idx][8*l +: 8] = data_wdata_o[8*l +: 8];
      end
    end
    gnt_wait = int'(rnd[7:6]);
    op_grants++;
  endtask

  // all inputs change on the falling edge
  task automatic drive_cycle();
    cycle++;
    if (!op_active && ops_started < NUM_OPS) start_op();
    lsu_req_i         = op_req;
    adder_result_ex_i = addr_incr_req_o ? op_addr + 32'd4 : op_addr;
    data_gnt_i        = (gnt_wait == 0);
    if (op_req && gnt_wait > 0) gnt_wait--;
    if (q_due.size() > 0 && q_due[0] <= cycle) begin
      data_rvalid_i  = 1'b1;
      data_bus_err_i = q_err[0];
      data_rdata_i   = q_rdata[0];
    end else begin
      data_rvalid_i  = 1'b0;
      data_bus_err_i = 1'b0;
      data_rdata_i   = $random(seed);
    end
  endtask

  // outputs have settled by mid-cycle
  task automatic sample_cycle();
    if (q_due.size() == 0 && !lsu_req_i) begin
      check_eq(32'(busy_o), 32'd0, "busy_o with nothing outstanding");
    end
    if (data_rvalid_i) begin
      void'(q_rdata.pop_front());
      void'(q_err.pop_front());
      void'(q_due.pop_front());
    end
    if (data_req_o && data_gnt_i) accept_grant();
    if (lsu_req_done_o) begin
      op_dones++;
      op_req = 1'b0;
    end
    if (lsu_resp_valid_o) finish_op();
  endtask

  initial begin
    lsu_req_i = 1'b0;
    lsu_we_i = 1'b0;
    lsu_type_i = lsu_word;
    lsu_sign_ext_i = 1'b0;
    lsu_wdata_i = '0;
    adder_result_ex_i = '0;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_bus_err_i = 1'b0;
    data_rdata_i = '0;
    seed = 32'h92c8830f;
    cycle = 0;
    gnt_wait = 0;
    errors = 0;
    checks = 0;
    timeouts = 0;
    ops_started = 0;
    ops_done = 0;
    op_active = 1'b0;
    op_req = 1'b0;
    op_addr = '0;
    // odd multiplier keeps every byte address distinct
    for (int b = 0; b < 256; b++) begin
      shadow[b] = 8'((b * 37 + 11) & 255);
      mem[b / 4][8*(b % 4) +: 8] = shadow[b];
    end
    @(posedge rst_ni);
    while (ops_done < NUM_OPS && cycle < MAX_CYCLES) begin
      @(negedge clk_i);
      drive_cycle();
      #10;
      sample_cycle();
    end
    if (ops_done < NUM_OPS) begin
      timeouts = 1;
      $display("timeout: only %0d of %0d operations finished in %0d cycles",
               ops_done, NUM_OPS, cycle);
    end
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/tb_clk_gen.sv */
// clock and reset for the testbench
// 40 ns clock, reset low for the first 8 cycles, released on a falling edge
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // release away from the active edge
  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire
